// ==== arcade_io_macros.svh ====
// Arcade I/O shared constants
// FIFO sizing, overlay window and PS/2 set-2 key codes

`ifndef ARCADE_IO_MACROS_SVH
`define ARCADE_IO_MACROS_SVH

// Pixel FIFO depth in words
`define FIFO_DEPTH       128
// Ready flag high while fill count is below this
`define FIFO_READY_LEVEL 120

// Debug overlay window, top-left corner
`define OVERLAY_W 64
`define OVERLAY_H 10

// Player 1 keys
`define KEY_UP    8'h75
`define KEY_DOWN  8'h72
`define KEY_LEFT  8'h6B
`define KEY_RIGHT 8'h74
`define KEY_CTRL  8'h14
`define KEY_ALT   8'h11
`define KEY_SPACE 8'h29
`define KEY_1     8'h16
`define KEY_5     8'h2E

// Player 2 keys
`define KEY_2     8'h1E
`define KEY_6     8'h36
`define KEY_A     8'h1C
`define KEY_S     8'h1B
`define KEY_Q     8'h15
`define KEY_R     8'h2D
`define KEY_F     8'h2B
`define KEY_D     8'h23
`define KEY_G     8'h34

// Shared pause key
`define KEY_P     8'h4D

`endif

// ==== arcade_video_pkg.sv ====
// Video-side types for the arcade I/O section
// Debug word seen as tag plus PC, or as 32 raw bar bits

package arcade_video_pkg;

  // Field view, as written by the capture register
  typedef struct packed {
    // Upper byte, joystick bits or all-ones marker
    logic [7:0]  tag;
    // Low 24 bits of the CPU program counter
    logic [23:0] pc;
  } debug_fields_t;

  // One word, two decodings
  typedef union packed {
    debug_fields_t f;
    // Bar display reads single bits from here
    logic [31:0]   raw;
  } debug_word_u;

endpackage

// ==== player_controls.sv ====
// Player controls
// Latches PS/2 key levels and merges them with the joystick words

`timescale 1ns/1ps

`include "arcade_io_macros.svh"

module player_controls (
  input  logic        CLK_VIDEO,
  input  logic        core_sreset,
  input  logic [10:0] ps2_key_i,
  input  logic [9:0]  joystick_0_i,
  input  logic [9:0]  joystick_1_i,
  output logic [8:0]  player_1_o,
  output logic [8:0]  player_2_o,
  output logic        pause_o
);

  //////////////////////////////////////////////////
  // Keyboard event decode
  //////////////////////////////////////////////////

  logic       old_toggle;
  logic       key_event;
  logic       pressed;
  logic [7:0] code;

  // Player 1 key levels
  logic key_up, key_down, key_left, key_right;
  logic key_ctrl, key_alt, key_space, key_1, key_5;
  // Player 2 key levels
  logic key_r, key_f, key_d, key_g;
  logic key_a, key_s, key_q, key_2, key_6;
  logic key_p;

  assign pressed   = ps2_key_i[9];
  assign code      = ps2_key_i[7:0];
  // Any flip of bit 10 marks a new event
  assign key_event = ps2_key_i[10] != old_toggle;

  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      old_toggle <= 1'b0;
      {key_up, key_down, key_left, key_right}         <= '0;
      {key_ctrl, key_alt, key_space, key_1, key_5}    <= '0;
      {key_r, key_f, key_d, key_g}                    <= '0;
      {key_a, key_s, key_q, key_2, key_6}             <= '0;
      key_p <= 1'b0;
    end else begin
      old_toggle <= ps2_key_i[10];
      if (key_event) begin
        // Make sets the level, break clears it
        case (code)
          `KEY_UP:    key_up    <= pressed;
          `KEY_DOWN:  key_down  <= pressed;
          `KEY_LEFT:  key_left  <= pressed;
          `KEY_RIGHT: key_right <= pressed;
          `KEY_CTRL:  key_ctrl  <= pressed;
          `KEY_ALT:   key_alt   <= pressed;
          `KEY_SPACE: key_space <= pressed;
          `KEY_1:     key_1     <= pressed;
          `KEY_5:     key_5     <= pressed;
          `KEY_R:     key_r     <= pressed;
          `KEY_F:     key_f     <= pressed;
          `KEY_D:     key_d     <= pressed;
          `KEY_G:     key_g     <= pressed;
          `KEY_A:     key_a     <= pressed;
          `KEY_S:     key_s     <= pressed;
          `KEY_Q:     key_q     <= pressed;
          `KEY_2:     key_2     <= pressed;
          `KEY_6:     key_6     <= pressed;
          `KEY_P:     key_p     <= pressed;
          // Unmapped codes are ignored
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Merge with joysticks
  //////////////////////////////////////////////////

  // Word order from bit 0: up, down, left, right, b1, b2, b3, start, coin
  // Joystick order from bit 0: right, left, down, up, b1..b3, start, coin
  assign player_1_o = {
    key_5     | joystick_0_i[8],
    key_1     | joystick_0_i[7],
    key_space | joystick_0_i[6],
    key_alt   | joystick_0_i[5],
    key_ctrl  | joystick_0_i[4],
    key_right | joystick_0_i[0],
    key_left  | joystick_0_i[1],
    key_down  | joystick_0_i[2],
    key_up    | joystick_0_i[3]
  };

  assign player_2_o = {
    key_6 | joystick_1_i[8],
    key_2 | joystick_1_i[7],
    key_q | joystick_1_i[6],
    key_s | joystick_1_i[5],
    key_a | joystick_1_i[4],
    key_g | joystick_1_i[0],
    key_d | joystick_1_i[1],
    key_f | joystick_1_i[2],
    key_r | joystick_1_i[3]
  };

  // Only joystick 0 carries a pause button
  assign pause_o = key_p | joystick_0_i[9];

endmodule

// ==== pixel_fifo.sv ====
// Pixel FIFO
// Single-clock show-ahead buffer with a fill-level ready flag

`timescale 1ns/1ps

`include "arcade_io_macros.svh"

module pixel_fifo (
  input  logic        CLK_VIDEO,
  input  logic        core_sreset,
  input  logic        wr_i,
  input  logic [15:0] data_i,
  input  logic        pop_i,
  output logic [15:0] head_o,
  output logic        empty_o,
  output logic        ready_o
);

  localparam int AW = $clog2(`FIFO_DEPTH);

  logic [15:0] mem [`FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign full    = count == (AW+1)'(`FIFO_DEPTH);
  assign empty_o = count == '0;
  // Writes into a full buffer are dropped
  assign do_wr   = wr_i && !full;
  assign do_rd   = pop_i && !empty_o;

  // Head word visible without a read cycle
  assign head_o  = mem[rd_ptr];
  // Producer throttle, a few words of slack below full
  assign ready_o = count < (AW+1)'(`FIFO_READY_LEVEL);

  // Storage
  always_ff @(posedge CLK_VIDEO) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer ignored the ready flag long enough to overflow
  a_no_write_full : assert property (@(posedge CLK_VIDEO) disable iff (core_sreset)
    !(wr_i && full))
    else $error("pixel_fifo: write while full, word lost");

  // Reader popped without data waiting
  a_no_pop_empty : assert property (@(posedge CLK_VIDEO) disable iff (core_sreset)
    !(pop_i && empty_o))
    else $error("pixel_fifo: pop while empty");

endmodule

// ==== debug_capture.sv ====
// Debug capture
// Holds the traced CPU PC and a tag byte for the bar overlay

`timescale 1ns/1ps

module debug_capture
  import arcade_video_pkg::*;
(
  input  logic        CLK_VIDEO,
  input  logic        core_sreset,
  input  logic        pc_write_i,
  input  logic [31:0] pc_i,
  input  logic [9:0]  joystick_0_i,
  output debug_word_u debug_word_o
);

  logic high_byte_set;

  // Trace strobe with something in the upper byte
  assign high_byte_set = pc_write_i && (pc_i[31:24] != 8'h00);

  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      debug_word_o <= '0;
    end else begin
      // PC field only moves on a trace strobe
      if (pc_write_i) begin
        debug_word_o.f.pc <= pc_i[23:0];
      end

      // Tag lights fully for one cycle as a marker
      if (high_byte_set) begin
        debug_word_o.f.tag <= 8'hFF;
      end else begin
        // Otherwise mirror live inputs
        debug_word_o.f.tag <= joystick_0_i[7:0];
      end
    end
  end

endmodule

// ==== video_out.sv ====
// Video output stage
// Locks onto the frame, drains the pixel FIFO and drives registered VGA pins

`timescale 1ns/1ps

`include "arcade_io_macros.svh"

module video_out
  import arcade_video_pkg::*;
(
  input  logic        CLK_VIDEO,
  input  logic        core_sreset,
  input  logic        debug_en_i,
  input  debug_word_u debug_word_i,
  input  logic [8:0]  hc_i,
  input  logic [8:0]  vc_i,
  input  logic        hblank_i,
  input  logic        vblank_i,
  input  logic        hsync_i,
  input  logic        vsync_i,
  input  logic        video_enable_i,
  input  logic [15:0] head_i,
  input  logic        empty_i,
  output logic        pop_o,
  output logic [7:0]  vga_r_o,
  output logic [7:0]  vga_g_o,
  output logic [7:0]  vga_b_o,
  output logic        vga_hs_o,
  output logic        vga_vs_o,
  output logic        vga_de_o
);

  //////////////////////////////////////////////////
  // Frame lock and FIFO drain
  //////////////////////////////////////////////////

  logic lock_q;

  // First corner blanking with data waiting aligns the stream
  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      lock_q <= 1'b0;
    end else if (hblank_i && vblank_i && !empty_i) begin
      lock_q <= 1'b1;
    end
  end

  // One word per enabled pixel once locked
  assign pop_o = video_enable_i && lock_q && !empty_i;

  //////////////////////////////////////////////////
  // Colour expansion and overlay
  //////////////////////////////////////////////////

  logic [7:0] exp_r, exp_g, exp_b;
  logic       in_overlay;
  logic [4:0] bar_idx;
  logic [7:0] bar_level;

  // RGB555, top bits repeated into the low end
  assign exp_r = {head_i[14:10], head_i[14:12]};
  assign exp_g = {head_i[9:5],   head_i[9:7]};
  assign exp_b = {head_i[4:0],   head_i[4:2]};

  assign in_overlay = debug_en_i && (hc_i < 9'(`OVERLAY_W)) && (vc_i < 9'(`OVERLAY_H));
  // Two columns per bar, MSB on the left
  assign bar_idx    = 5'd31 - hc_i[5:1];
  assign bar_level  = debug_word_i.raw[bar_idx] ? 8'hFF : 8'h00;

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  always_ff @(posedge CLK_VIDEO) begin
    if (core_sreset) begin
      vga_r_o  <= '0;
      vga_g_o  <= '0;
      vga_b_o  <= '0;
      vga_hs_o <= 1'b0;
      vga_vs_o <= 1'b0;
      vga_de_o <= 1'b0;
    end else begin
      vga_hs_o <= hsync_i;
      vga_vs_o <= vsync_i;
      vga_de_o <= video_enable_i;
      if (video_enable_i && in_overlay) begin
        // Bars cover whatever is popped beneath
        vga_r_o <= bar_level;
        vga_g_o <= bar_level;
        vga_b_o <= bar_level;
      end else if (pop_o) begin
        vga_r_o <= exp_r;
        vga_g_o <= exp_g;
        vga_b_o <= exp_b;
      end else begin
        // Blanking or underrun shows black
        vga_r_o <= '0;
        vga_g_o <= '0;
        vga_b_o <= '0;
      end
    end
  end

  // Once aligned the stream never drops lock on its own
  a_lock_sticky : assert property (@(posedge CLK_VIDEO) disable iff (core_sreset)
    $fell(lock_q) |-> $past(core_sreset))
    else $error("video_out: lock lost outside reset");

endmodule

// ==== arcade_io_top.sv ====
// Arcade I/O top level
// Controls, pixel FIFO, debug capture and video output on one clock

`timescale 1ns/1ps

module arcade_io_top
  import arcade_video_pkg::*;
(
  input  logic        CLK_VIDEO,
  input  logic        core_sreset,
  // Controls
  input  logic [10:0] ps2_key_i,
  input  logic [9:0]  joystick_0_i,
  input  logic [9:0]  joystick_1_i,
  output logic [8:0]  player_1_o,
  output logic [8:0]  player_2_o,
  output logic        pause_o,
  // Pixel stream in
  input  logic        pixel_wr_i,
  input  logic [15:0] pixel_i,
  output logic        fifo_ready_o,
  // CPU trace
  input  logic        pc_write_i,
  input  logic [31:0] pc_i,
  input  logic        debug_en_i,
  // Video timing
  input  logic [8:0]  hc_i,
  input  logic [8:0]  vc_i,
  input  logic        hblank_i,
  input  logic        vblank_i,
  input  logic        hsync_i,
  input  logic        vsync_i,
  input  logic        video_enable_i,
  // VGA out
  output logic [7:0]  vga_r_o,
  output logic [7:0]  vga_g_o,
  output logic [7:0]  vga_b_o,
  output logic        vga_hs_o,
  output logic        vga_vs_o,
  output logic        vga_de_o
);

  logic [15:0] fifo_head;
  logic        fifo_empty;
  logic        fifo_pop;
  debug_word_u debug_word;

  player_controls player_controls_i (
    .CLK_VIDEO   (CLK_VIDEO),
    .core_sreset (core_sreset),
    .ps2_key_i   (ps2_key_i),
    .joystick_0_i(joystick_0_i),
    .joystick_1_i(joystick_1_i),
    .player_1_o  (player_1_o),
    .player_2_o  (player_2_o),
    .pause_o     (pause_o)
  );

  pixel_fifo pixel_fifo_i (
    .CLK_VIDEO  (CLK_VIDEO),
    .core_sreset(core_sreset),
    .wr_i       (pixel_wr_i),
    .data_i     (pixel_i),
    .pop_i      (fifo_pop),
    .head_o     (fifo_head),
    .empty_o    (fifo_empty),
    .ready_o    (fifo_ready_o)
  );

  debug_capture debug_capture_i (
    .CLK_VIDEO   (CLK_VIDEO),
    .core_sreset (core_sreset),
    .pc_write_i  (pc_write_i),
    .pc_i        (pc_i),
    .joystick_0_i(joystick_0_i),
    .debug_word_o(debug_word)
  );

  video_out video_out_i (
    .CLK_VIDEO     (CLK_VIDEO),
    .core_sreset   (core_sreset),
    .debug_en_i    (debug_en_i),
    .debug_word_i  (debug_word),
    .hc_i          (hc_i),
    .vc_i          (vc_i),
    .hblank_i      (hblank_i),
    .vblank_i      (vblank_i),
    .hsync_i       (hsync_i),
    .vsync_i       (vsync_i),
    .video_enable_i(video_enable_i),
    .head_i        (fifo_head),
    .empty_i       (fifo_empty),
    .pop_o         (fifo_pop),
    .vga_r_o       (vga_r_o),
    .vga_g_o       (vga_g_o),
    .vga_b_o       (vga_b_o),
    .vga_hs_o      (vga_hs_o),
    .vga_vs_o      (vga_vs_o),
    .vga_de_o      (vga_de_o)
  );

endmodule

// ==== tb_arcade_io.sv ====
// Testbench for the arcade I/O top level
// Directed tests for controls, pixel FIFO, video stream and debug bars

`timescale 1ns/1ps

`include "arcade_io_macros.svh"

module tb_arcade_io;

  logic        CLK_VIDEO;
  logic        core_sreset;
  logic [10:0] ps2_key_i;
  logic [9:0]  joystick_0_i;
  logic [9:0]  joystick_1_i;
  logic [8:0]  player_1_o;
  logic [8:0]  player_2_o;
  logic        pause_o;
  logic        pixel_wr_i;
  logic [15:0] pixel_i;
  logic        fifo_ready_o;
  logic        pc_write_i;
  logic [31:0] pc_i;
  logic        debug_en_i;
  logic [8:0]  hc_i;
  logic [8:0]  vc_i;
  logic        hblank_i;
  logic        vblank_i;
  logic        hsync_i;
  logic        vsync_i;
  logic        video_enable_i;
  logic [7:0]  vga_r_o;
  logic [7:0]  vga_g_o;
  logic [7:0]  vga_b_o;
  logic        vga_hs_o;
  logic        vga_vs_o;
  logic        vga_de_o;

  // Stimulus generator state
  logic [31:0] lfsr_state;
  // Key levels: p1 bits 8..0, p2 bits 17..9, pause bit 18
  logic [18:0] key_levels;
  // Pixels written but not yet seen on the VGA side
  logic [15:0] expected_q[$];

  arcade_io_top arcade_io_top_i (.*);

  // 40 ns video clock
  initial begin
    CLK_VIDEO = 1'b0;
    forever #20 CLK_VIDEO = ~CLK_VIDEO;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  // Joystick right/left/down/up reordered into up/down/left/right
  function automatic logic [8:0] joy_to_word(input logic [9:0] joy);
    return {joy[8:4], joy[0], joy[1], joy[2], joy[3]};
  endfunction

  // RGB555 to 24 bits, top 3 bits of each channel repeated below
  function automatic logic [23:0] expand_pixel(input logic [15:0] p);
    return {p[14:10], p[14:12], p[9:5], p[9:7], p[4:0], p[4:2]};
  endfunction

  task automatic stop_run();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected)
    else begin
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h",
               $time, name, actual, expected);
      stop_run();
    end
  endtask

  // Drive happens at the falling edge, so step to the next one
  task automatic next_cycle();
    @(posedge CLK_VIDEO);
    @(negedge CLK_VIDEO);
  endtask

  task automatic check_controls();
    check_value("player_1_o", player_1_o, key_levels[8:0] | joy_to_word(joystick_0_i));
    check_value("player_2_o", player_2_o, key_levels[17:9] | joy_to_word(joystick_1_i));
    check_value("pause_o", pause_o, key_levels[18] | joystick_0_i[9]);
  endtask

  task automatic check_video(input logic [23:0] rgb, input logic de,
                             input logic hs, input logic vs);
    check_value("vga_r_o", vga_r_o, rgb[23:16]);
    check_value("vga_g_o", vga_g_o, rgb[15:8]);
    check_value("vga_b_o", vga_b_o, rgb[7:0]);
    check_value("vga_de_o", vga_de_o, de);
    check_value("vga_hs_o", vga_hs_o, hs);
    check_value("vga_vs_o", vga_vs_o, vs);
  endtask

  // One PS/2 event, latched at the next rising edge
  task automatic send_key(input logic [7:0] code, input int slot, input logic pressed);
    ps2_key_i = {~ps2_key_i[10], pressed, 1'b0, code};
    #1;
    // Not yet sampled
    check_controls();
    next_cycle();
    key_levels[slot] = pressed;
    check_controls();
  endtask

  task automatic write_pixel(input logic [15:0] word);
    pixel_wr_i = 1'b1;
    pixel_i = word;
    expected_q.push_back(word);
    next_cycle();
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_values();
    check_video(24'h0, 1'b0, 1'b0, 1'b0);
    check_controls();
    check_value("fifo_ready_o", fifo_ready_o, 1'b1);
  endtask

  task automatic test_keys();
    logic [7:0] codes [19];
    // Ordered by key_levels slot
    codes = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT, `KEY_CTRL, `KEY_ALT,
              `KEY_SPACE, `KEY_1, `KEY_5, `KEY_R, `KEY_F, `KEY_D, `KEY_G,
              `KEY_A, `KEY_S, `KEY_Q, `KEY_2, `KEY_6, `KEY_P};
    for (int k = 0; k < 19; k++) begin
      send_key(codes[k], k, 1'b1);
      send_key(codes[k], k, 1'b0);
    end
    // Hold one key per player plus pause under random sticks
    send_key(codes[2], 2, 1'b1);
    send_key(codes[14], 14, 1'b1);
    send_key(codes[18], 18, 1'b1);
    for (int n = 0; n < 16; n++) begin
      joystick_0_i = 10'(random_bits(10));
      joystick_1_i = 10'(random_bits(10));
      #1;
      // Joysticks are combinational, same cycle
      check_controls();
      next_cycle();
    end
    joystick_0_i = '0;
    joystick_1_i = '0;
    send_key(codes[2], 2, 1'b0);
    send_key(codes[14], 14, 1'b0);
    send_key(codes[18], 18, 1'b0);
  endtask

  task automatic test_fill();
    for (int n = 1; n <= `FIFO_READY_LEVEL; n++) begin
      write_pixel(16'(random_bits(16)));
      if (n == `FIFO_READY_LEVEL - 1) begin
        check_value("fifo_ready_o", fifo_ready_o, 1'b1);
      end
    end
    pixel_wr_i = 1'b0;
    check_value("fifo_ready_o", fifo_ready_o, 1'b0);
  endtask

  task automatic test_stream();
    logic en;
    logic hs;
    logic vs;
    int   cycles;
    hc_i = 9'd100;
    vc_i = 9'd100;
    // Not locked yet, DE follows enable but colour stays black
    for (int n = 0; n < 8; n++) begin
      en = random_bits(1);
      hs = random_bits(1);
      vs = random_bits(1);
      video_enable_i = en;
      hsync_i = hs;
      vsync_i = vs;
      next_cycle();
      check_video(24'h0, en, hs, vs);
    end
    // Corner blanking arms the stream
    video_enable_i = 1'b0;
    hblank_i = 1'b1;
    vblank_i = 1'b1;
    next_cycle();
    hblank_i = 1'b0;
    vblank_i = 1'b0;
    // Drain with random enable gaps
    cycles = 0;
    while (expected_q.size() > 0 && cycles < 4 * `FIFO_DEPTH) begin
      cycles++;
      en = random_bits(2) != 2'b00;
      hs = random_bits(1);
      vs = random_bits(1);
      video_enable_i = en;
      hsync_i = hs;
      vsync_i = vs;
      next_cycle();
      if (en) begin
        check_video(expand_pixel(expected_q.pop_front()), 1'b1, hs, vs);
      end else begin
        check_video(24'h0, 1'b0, hs, vs);
      end
    end
    if (expected_q.size() > 0) begin
      $display("Timed out after %0d cycles with %0d pixels still not shown",
               cycles, expected_q.size());
      stop_run();
    end
    // Underrun gives black with DE high
    video_enable_i = 1'b1;
    next_cycle();
    check_video(24'h0, 1'b1, hs, vs);
    check_value("fifo_ready_o", fifo_ready_o, 1'b1);
    video_enable_i = 1'b0;
  endtask

  task automatic test_debug();
    logic [9:0]  joy;
    logic [23:0] pc;
    logic [31:0] bars;
    debug_en_i = 1'b1;
    joy = 10'(random_bits(10));
    pc = 24'(random_bits(24));
    joystick_0_i = joy;
    pc_write_i = 1'b1;
    pc_i = {8'h00, pc};
    next_cycle();
    pc_write_i = 1'b0;
    // Tag from joystick 0, rest from the PC
    bars = {joy[7:0], pc};
    video_enable_i = 1'b1;
    for (int col = 0; col < `OVERLAY_W; col++) begin
      hc_i = 9'(col);
      vc_i = 9'(col % `OVERLAY_H);
      next_cycle();
      check_video(bars[31 - col / 2] ? 24'hFFFFFF : 24'h0, 1'b1, hsync_i, vsync_i);
    end
    // Non-zero upper byte lights the tag bars for one cycle
    joystick_0_i = '0;
    for (int bar = 0; bar < 8; bar++) begin
      video_enable_i = 1'b0;
      pc_write_i = 1'b1;
      pc_i = {1'b1, 7'(random_bits(7)), 24'(random_bits(24))};
      next_cycle();
      pc_write_i = 1'b0;
      video_enable_i = 1'b1;
      hc_i = 9'(2 * bar);
      vc_i = 9'd0;
      next_cycle();
      check_video(24'hFFFFFF, 1'b1, hsync_i, vsync_i);
      next_cycle();
      check_video(24'h0, 1'b1, hsync_i, vsync_i);
    end
    // Fresh pixels for the area outside the overlay
    video_enable_i = 1'b0;
    for (int n = 0; n < 4; n++) begin
      write_pixel(16'(random_bits(16)));
    end
    pixel_wr_i = 1'b0;
    video_enable_i = 1'b1;
    hc_i = 9'(`OVERLAY_W);
    vc_i = 9'd0;
    next_cycle();
    check_video(expand_pixel(expected_q.pop_front()), 1'b1, hsync_i, vsync_i);
    hc_i = 9'd0;
    vc_i = 9'(`OVERLAY_H);
    next_cycle();
    check_video(expand_pixel(expected_q.pop_front()), 1'b1, hsync_i, vsync_i);
    // Inside the overlay, bar 31 is dark and a word pops beneath it
    vc_i = 9'd0;
    next_cycle();
    check_video(24'h0, 1'b1, hsync_i, vsync_i);
    void'(expected_q.pop_front());
    hc_i = 9'd200;
    vc_i = 9'd200;
    next_cycle();
    check_video(expand_pixel(expected_q.pop_front()), 1'b1, hsync_i, vsync_i);
    video_enable_i = 1'b0;
    debug_en_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    lfsr_state = 32'h6123708d;
    key_levels = '0;
    core_sreset = 1'b1;
    ps2_key_i = '0;
    joystick_0_i = '0;
    joystick_1_i = '0;
    pixel_wr_i = 1'b0;
    pixel_i = '0;
    pc_write_i = 1'b0;
    pc_i = '0;
    debug_en_i = 1'b0;
    hc_i = '0;
    vc_i = '0;
    hblank_i = 1'b0;
    vblank_i = 1'b0;
    hsync_i = 1'b0;
    vsync_i = 1'b0;
    video_enable_i = 1'b0;
    repeat (16) @(posedge CLK_VIDEO);
    @(negedge CLK_VIDEO);
    core_sreset = 1'b0;
    test_reset_values();
    test_keys();
    test_fill();
    test_stream();
    test_debug();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== arcade_io.f ====
+incdir+.
arcade_video_pkg.sv
player_controls.sv
pixel_fifo.sv
debug_capture.sv
video_out.sv
arcade_io_top.sv
tb_arcade_io.sv

// ==== Bender.yml ====
package:
  name: arcade_io

export_include_dirs:
  - .

sources:
  - arcade_video_pkg.sv
  - player_controls.sv
  - pixel_fifo.sv
  - debug_capture.sv
  - video_out.sv
  - arcade_io_top.sv
  - target: test
    files:
      - tb_arcade_io.sv
